// File: hw/dtpu_pkg.sv
package dtpu_pkg;

  //////////////////////////////
  // array shape
  //////////////////////////////

  localparam int ROWS    = 4;
  localparam int WORD_W  = 64; // fifo and weight word
  localparam int LANES8  = 8;
  localparam int LANES16 = 4;
  localparam int RES_W   = 16; // one row sum per halfword of the result
  localparam int CNT_W   = 8;

  // csr byte map
  localparam logic [31:0] CSR_ADDR_PREC  = 32'd0;
  localparam logic [31:0] CSR_ADDR_COUNT = 32'd1;

  // one slot for the count byte, then one per weight row
  localparam logic [CNT_W-1:0] WFETCH_INIT = CNT_W'(ROWS + 1);

  //////////////////////////////
  // types
  //////////////////////////////

  typedef enum logic {
    PREC_INT8  = 1'b0,
    PREC_INT16 = 1'b1
  } precision_e;

  // same 64 bits, read as bytes or halfwords depending on precision
  typedef union packed {
    logic [LANES8-1:0][7:0]   b;
    logic [LANES16-1:0][15:0] h;
  } lane_word_u;

  typedef struct packed {
    precision_e precision;
    logic       issue;     // word popped from the input fifo this cycle
  } mxu_ctrl_t;

  typedef struct packed {
    logic        ce;
    logic [31:0] addr;
  } wm_req_t;

  typedef struct packed {
    logic        ce;
    logic [31:0] addr;
  } csr_req_t;

endpackage

// File: hw/dtpu_counter.sv
module dtpu_counter (
  input  logic                       clk,
  input  logic                       aresetn,
  input  logic                       load_i,
  input  logic [dtpu_pkg::CNT_W-1:0] value_i,
  input  logic                       dec_i,
  output logic [dtpu_pkg::CNT_W-1:0] count_o,
  output logic                       zero_o
);

  logic [dtpu_pkg::CNT_W-1:0] count_q;

  always_ff @(posedge clk) begin
    if (!aresetn) begin
      count_q <= '0;
    end else if (load_i) begin
      count_q <= value_i; // load wins over dec
    end else if (dec_i && !zero_o) begin
      count_q <= count_q - 1'b1; // sticks at zero
    end
  end

  assign count_o = count_q;
  assign zero_o  = (count_q == '0);

  //////////////////////////////
  // checks
  //////////////////////////////

  // the control unit must never count past the end
  a_no_dec_at_zero: assert property (
    @(posedge clk) disable iff (!aresetn)
    dec_i |-> !zero_o
  ) else $error("dtpu_counter: decrement requested at zero");

endmodule

// File: hw/dtpu_control.sv
module dtpu_control (
  input  logic                       clk,
  input  logic                       aresetn,
  // accelerator strobes
  input  logic                       cs_start_i,
  input  logic                       cs_continue_i,
  output logic                       cs_ready_o,
  output logic                       cs_done_o,
  output logic                       cs_idle_o,
  // csr port
  output dtpu_pkg::csr_req_t         csr_req_o,
  input  logic [7:0]                 csr_dout_i,
  // weight fetch
  output dtpu_pkg::wm_req_t          wm_req_o,
  output logic                       wm_cnt_load_o,
  output logic                       wm_cnt_dec_o,
  output logic [dtpu_pkg::CNT_W-1:0] wm_cnt_value_o,
  input  logic [dtpu_pkg::CNT_W-1:0] wm_cnt_i,
  input  logic                       wm_zero_i,
  // vectors remaining
  output logic                       vec_cnt_load_o,
  output logic                       vec_cnt_dec_o,
  output logic [dtpu_pkg::CNT_W-1:0] vec_cnt_value_o,
  input  logic                       vec_zero_i,
  // weight buffer
  output logic                       wb_capture_o,
  output logic [1:0]                 wb_row_o,
  // input fifo and array
  input  logic                       infifo_empty_i,
  output logic                       infifo_read_o,
  output dtpu_pkg::mxu_ctrl_t        mxu_ctrl_o,
  input  logic                       mxu_accept_i,
  input  logic                       mxu_drained_i
);

  typedef enum logic [2:0] {
    IDLE,
    CSR_PREC,
    CSR_COUNT,
    LOAD_W,
    STREAM,
    DONE
  } state_e;

  state_e               state_q;
  state_e               state_d;
  dtpu_pkg::precision_e prec_q;
  logic                 ready_q;
  logic                 cap_q;
  logic [1:0]           row_q;
  logic                 wm_fetch;
  logic                 pop;

  //////////////////////////////
  // state machine
  //////////////////////////////

  always_comb begin
    state_d = state_q;
    case (state_q)
      IDLE: begin
        if (cs_start_i) begin
          state_d = CSR_PREC;
        end
      end
      CSR_PREC:  state_d = CSR_COUNT;
      CSR_COUNT: state_d = LOAD_W;
      LOAD_W: begin
        // last row lands in the buffer on this edge
        if (wm_zero_i) begin
          state_d = vec_zero_i ? DONE : STREAM;
        end
      end
      STREAM: begin
        if (vec_zero_i && mxu_drained_i) begin
          state_d = DONE;
        end
      end
      DONE: begin
        if (cs_continue_i) begin
          state_d = IDLE;
        end
      end
      default: state_d = IDLE;
    endcase
  end

  always_ff @(posedge clk) begin
    if (!aresetn) begin
      state_q <= IDLE;
      prec_q  <= dtpu_pkg::PREC_INT8;
      ready_q <= 1'b0;
      cap_q   <= 1'b0;
    end else begin
      state_q <= state_d;
      ready_q <= (state_q == IDLE) && cs_start_i;
      cap_q   <= wm_fetch; // ram data is one clock behind the address
      if (state_q == CSR_COUNT) begin
        prec_q <= dtpu_pkg::precision_e'(csr_dout_i[0]); // byte 0 is on dout now
      end
    end
  end

  always_ff @(posedge clk) begin
    row_q <= wm_req_o.addr[1:0];
  end

  //////////////////////////////
  // csr and weight fetch
  //////////////////////////////

  assign csr_req_o.ce   = (state_q == CSR_PREC) || (state_q == CSR_COUNT);
  assign csr_req_o.addr = (state_q == CSR_COUNT) ? dtpu_pkg::CSR_ADDR_COUNT
                                                 : dtpu_pkg::CSR_ADDR_PREC;

  // first LOAD_W cycle only picks up the count byte
  assign wm_fetch      = (state_q == LOAD_W) && !wm_zero_i && (wm_cnt_i <= dtpu_pkg::ROWS);
  assign wm_req_o.ce   = wm_fetch;
  assign wm_req_o.addr = wm_fetch ? 32'(dtpu_pkg::ROWS) - 32'(wm_cnt_i) : '0;

  assign wm_cnt_load_o  = (state_q == CSR_COUNT);
  assign wm_cnt_value_o = dtpu_pkg::WFETCH_INIT;
  assign wm_cnt_dec_o   = (state_q == LOAD_W) && !wm_zero_i;

  assign vec_cnt_load_o  = (state_q == LOAD_W) && (wm_cnt_i == dtpu_pkg::WFETCH_INIT);
  assign vec_cnt_value_o = csr_dout_i;

  assign wb_capture_o = cap_q;
  assign wb_row_o     = row_q;

  //////////////////////////////
  // streaming
  //////////////////////////////

  assign pop = (state_q == STREAM) && !infifo_empty_i && mxu_accept_i && !vec_zero_i;

  assign infifo_read_o        = pop;
  assign vec_cnt_dec_o        = pop;
  assign mxu_ctrl_o.issue     = pop;
  assign mxu_ctrl_o.precision = prec_q;

  assign cs_ready_o = ready_q;
  assign cs_done_o  = (state_q == DONE);
  assign cs_idle_o  = (state_q == IDLE);

  //////////////////////////////
  // checks
  //////////////////////////////

  a_no_pop_empty: assert property (
    @(posedge clk) disable iff (!aresetn)
    infifo_read_o |-> !infifo_empty_i
  ) else $error("dtpu_control: input fifo popped while empty");

endmodule

// File: hw/weight_buffer.sv
module weight_buffer (
  input  logic                                     clk,
  input  logic                                     aresetn,
  input  logic                                     capture_i,
  input  logic [1:0]                               row_i,
  input  logic [dtpu_pkg::WORD_W-1:0]              wm_dout_i,
  output dtpu_pkg::lane_word_u [dtpu_pkg::ROWS-1:0] weights_o
);

  // one 64 bit word per matrix row
  dtpu_pkg::lane_word_u [dtpu_pkg::ROWS-1:0] weights_q;

  always_ff @(posedge clk) begin
    if (!aresetn) begin
      weights_q <= '0;
    end else if (capture_i) begin
      weights_q[row_i] <= wm_dout_i; // kept until the next fetch
    end
  end

  assign weights_o = weights_q;

endmodule

// File: hw/mxu.sv
module mxu (
  input  logic                                     clk,
  input  logic                                     aresetn,
  input  dtpu_pkg::mxu_ctrl_t                      ctrl_i,
  input  dtpu_pkg::lane_word_u                     act_i,
  input  dtpu_pkg::lane_word_u [dtpu_pkg::ROWS-1:0] weights_i,
  input  logic                                     outfifo_full_i,
  output logic                                     accept_o,
  output logic                                     drained_o,
  output logic                                     outfifo_write_o,
  output logic [dtpu_pkg::WORD_W-1:0]              outfifo_din_o
);

  logic s1_valid_q;
  logic s2_valid_q;
  logic s2_stall;

  // lane products, one halfword each
  logic [dtpu_pkg::ROWS-1:0][dtpu_pkg::LANES8-1:0][dtpu_pkg::RES_W-1:0] prod_d;
  logic [dtpu_pkg::ROWS-1:0][dtpu_pkg::LANES8-1:0][dtpu_pkg::RES_W-1:0] prod_q;
  logic [dtpu_pkg::ROWS-1:0][dtpu_pkg::RES_W-1:0]                       sum_d;
  logic [dtpu_pkg::WORD_W-1:0]                                          res_q;

  assign s2_stall  = s2_valid_q && outfifo_full_i;
  assign accept_o  = !s2_stall; // whole pipe freezes together
  assign drained_o = !s1_valid_q && !s2_valid_q;

  //////////////////////////////
  // stage 1 multiply
  //////////////////////////////

  always_comb begin
    prod_d = '0;
    for (int r = 0; r < dtpu_pkg::ROWS; r++) begin
      if (ctrl_i.precision == dtpu_pkg::PREC_INT16) begin
        // upper four slots stay zero
        for (int l = 0; l < dtpu_pkg::LANES16; l++) begin
          prod_d[r][l] = $signed(act_i.h[l]) * $signed(weights_i[r].h[l]); // wraps mod 2^16
        end
      end else begin
        for (int l = 0; l < dtpu_pkg::LANES8; l++) begin
          prod_d[r][l] = $signed(act_i.b[l]) * $signed(weights_i[r].b[l]);
        end
      end
    end
  end

  //////////////////////////////
  // stage 2 row sum
  //////////////////////////////

  always_comb begin
    for (int r = 0; r < dtpu_pkg::ROWS; r++) begin
      sum_d[r] = '0;
      for (int l = 0; l < dtpu_pkg::LANES8; l++) begin
        sum_d[r] = sum_d[r] + prod_q[r][l];
      end
    end
  end

  always_ff @(posedge clk) begin
    if (!aresetn) begin
      s1_valid_q <= 1'b0;
      s2_valid_q <= 1'b0;
    end else if (!s2_stall) begin
      s1_valid_q <= ctrl_i.issue;
      s2_valid_q <= s1_valid_q;
    end
  end

  always_ff @(posedge clk) begin
    if (!s2_stall) begin
      prod_q <= prod_d;
      res_q  <= sum_d; // row r at bits 16r and up
    end
  end

  assign outfifo_write_o = s2_valid_q && !outfifo_full_i;
  assign outfifo_din_o   = res_q;

  //////////////////////////////
  // checks
  //////////////////////////////

  a_no_write_full: assert property (
    @(posedge clk) disable iff (!aresetn)
    outfifo_write_o |-> !outfifo_full_i
  ) else $error("mxu: output fifo written while full");

endmodule

// File: hw/dtpu_core.sv
module dtpu_core (
  input  logic        clk,
  input  logic        aresetn,

  //////////////////////////////
  // csr memory
  output logic        csr_ce_o,
  output logic [31:0] csr_addr_o,
  output logic [7:0]  csr_din_o,
  output logic        csr_we_o,
  output logic        csr_clk_o,
  input  logic [7:0]  csr_dout_i,

  //////////////////////////////
  // weight memory
  output logic        wm_ce_o,
  output logic [31:0] wm_addr_o,
  output logic [63:0] wm_din_o,
  output logic        wm_we_o,
  output logic        wm_clk_o,
  input  logic [63:0] wm_dout_i,

  //////////////////////////////
  // fifos
  input  logic [63:0] infifo_dout_i,
  input  logic        infifo_empty_i,
  output logic        infifo_read_o,
  output logic [63:0] outfifo_din_o,
  output logic        outfifo_write_o,
  input  logic        outfifo_full_i,

  //////////////////////////////
  // host control
  input  logic        cs_start_i,
  input  logic        cs_continue_i,
  output logic        cs_ready_o,
  output logic        cs_done_o,
  output logic        cs_idle_o
);

  dtpu_pkg::csr_req_t                        csr_req;
  dtpu_pkg::wm_req_t                         wm_req;
  logic                                      wm_cnt_load;
  logic                                      wm_cnt_dec;
  logic [dtpu_pkg::CNT_W-1:0]                wm_cnt_value;
  logic [dtpu_pkg::CNT_W-1:0]                wm_cnt;
  logic                                      wm_zero;
  logic                                      vec_cnt_load;
  logic                                      vec_cnt_dec;
  logic [dtpu_pkg::CNT_W-1:0]                vec_cnt_value;
  logic                                      vec_zero;
  logic                                      wb_capture;
  logic [1:0]                                wb_row;
  dtpu_pkg::mxu_ctrl_t                       mxu_ctrl;
  logic                                      mxu_accept;
  logic                                      mxu_drained;
  dtpu_pkg::lane_word_u [dtpu_pkg::ROWS-1:0] weights;

  dtpu_control u_control (
    .clk             (clk),
    .aresetn         (aresetn),
    .cs_start_i      (cs_start_i),
    .cs_continue_i   (cs_continue_i),
    .cs_ready_o      (cs_ready_o),
    .cs_done_o       (cs_done_o),
    .cs_idle_o       (cs_idle_o),
    .csr_req_o       (csr_req),
    .csr_dout_i      (csr_dout_i),
    .wm_req_o        (wm_req),
    .wm_cnt_load_o   (wm_cnt_load),
    .wm_cnt_dec_o    (wm_cnt_dec),
    .wm_cnt_value_o  (wm_cnt_value),
    .wm_cnt_i        (wm_cnt),
    .wm_zero_i       (wm_zero),
    .vec_cnt_load_o  (vec_cnt_load),
    .vec_cnt_dec_o   (vec_cnt_dec),
    .vec_cnt_value_o (vec_cnt_value),
    .vec_zero_i      (vec_zero),
    .wb_capture_o    (wb_capture),
    .wb_row_o        (wb_row),
    .infifo_empty_i  (infifo_empty_i),
    .infifo_read_o   (infifo_read_o),
    .mxu_ctrl_o      (mxu_ctrl),
    .mxu_accept_i    (mxu_accept),
    .mxu_drained_i   (mxu_drained)
  );

  // weight address counter
  dtpu_counter u_wm_cnt (
    .clk     (clk),
    .aresetn (aresetn),
    .load_i  (wm_cnt_load),
    .value_i (wm_cnt_value),
    .dec_i   (wm_cnt_dec),
    .count_o (wm_cnt),
    .zero_o  (wm_zero)
  );

  // vectors still to issue
  dtpu_counter u_vec_cnt (
    .clk     (clk),
    .aresetn (aresetn),
    .load_i  (vec_cnt_load),
    .value_i (vec_cnt_value),
    .dec_i   (vec_cnt_dec),
    .count_o (),
    .zero_o  (vec_zero)
  );

  weight_buffer u_weight_buffer (
    .clk       (clk),
    .aresetn   (aresetn),
    .capture_i (wb_capture),
    .row_i     (wb_row),
    .wm_dout_i (wm_dout_i),
    .weights_o (weights)
  );

  mxu u_mxu (
    .clk             (clk),
    .aresetn         (aresetn),
    .ctrl_i          (mxu_ctrl),
    .act_i           (infifo_dout_i),
    .weights_i       (weights),
    .outfifo_full_i  (outfifo_full_i),
    .accept_o        (mxu_accept),
    .drained_o       (mxu_drained),
    .outfifo_write_o (outfifo_write_o),
    .outfifo_din_o   (outfifo_din_o)
  );

  // read-only ram ports on the core clock
  assign csr_ce_o   = csr_req.ce;
  assign csr_addr_o = csr_req.addr;
  assign csr_din_o  = '0;
  assign csr_we_o   = 1'b0;
  assign csr_clk_o  = clk;

  assign wm_ce_o   = wm_req.ce;
  assign wm_addr_o = wm_req.addr;
  assign wm_din_o  = '0;
  assign wm_we_o   = 1'b0;
  assign wm_clk_o  = clk;

endmodule

// File: verif/tb_clock_gen.sv
module tb_clock_gen (
  output logic clk_o,
  output logic aresetn_o
);

  initial begin
    clk_o = 1'b0;
    forever #2 clk_o = ~clk_o; // period 4
  end

  initial begin
    aresetn_o = 1'b0;
    repeat (10) @(posedge clk_o);
    #1 aresetn_o = 1'b1; // released like any other input
  end

endmodule

// File: verif/tb_dtpu.sv
module tb_dtpu;

  logic        clk;
  logic        aresetn;
  logic        csr_ce;
  logic [31:0] csr_addr;
  logic [7:0]  csr_din;
  logic        csr_we;
  logic        csr_clk;
  logic [7:0]  csr_dout;
  logic        wm_ce;
  logic [31:0] wm_addr;
  logic [63:0] wm_din;
  logic        wm_we;
  logic        wm_clk;
  logic [63:0] wm_dout;
  logic [63:0] infifo_dout;
  logic        infifo_empty;
  logic        infifo_read;
  logic [63:0] outfifo_din;
  logic        outfifo_write;
  logic        outfifo_full;
  logic        cs_start;
  logic        cs_continue;
  logic        cs_ready;
  logic        cs_done;
  logic        cs_idle;

  // memory and fifo models
  logic [7:0]  csr_mem [4];
  logic [63:0] wm_mem [4];
  logic [63:0] in_q [$];
  logic [63:0] out_q [$];
  int          pop_cyc_q [$];
  logic        csr_pend;
  logic [7:0]  csr_next;
  logic        wm_pend;
  logic [63:0] wm_next;
  logic        bp_on;
  logic        gap_on;
  logic        lat_check;
  logic [31:0] rng_state;
  logic [31:0] pat_state;
  int          cyc;
  int          ready_cnt;
  int          err_cnt;
  int          test_cnt;

  tb_clock_gen u_clock_gen (
    .clk_o     (clk),
    .aresetn_o (aresetn)
  );

  dtpu_core dut0 (
    .clk             (clk),
    .aresetn         (aresetn),
    .csr_ce_o        (csr_ce),
    .csr_addr_o      (csr_addr),
    .csr_din_o       (csr_din),
    .csr_we_o        (csr_we),
    .csr_clk_o       (csr_clk),
    .csr_dout_i      (csr_dout),
    .wm_ce_o         (wm_ce),
    .wm_addr_o       (wm_addr),
    .wm_din_o        (wm_din),
    .wm_we_o         (wm_we),
    .wm_clk_o        (wm_clk),
    .wm_dout_i       (wm_dout),
    .infifo_dout_i   (infifo_dout),
    .infifo_empty_i  (infifo_empty),
    .infifo_read_o   (infifo_read),
    .outfifo_din_o   (outfifo_din),
    .outfifo_write_o (outfifo_write),
    .outfifo_full_i  (outfifo_full),
    .cs_start_i      (cs_start),
    .cs_continue_i   (cs_continue),
    .cs_ready_o      (cs_ready),
    .cs_done_o       (cs_done),
    .cs_idle_o       (cs_idle)
  );

  //////////////////////////////
  // helpers
  //////////////////////////////

  function automatic logic [31:0] xorshift32(input logic [31:0] x);
    logic [31:0] y;
    y = x ^ (x << 13);
    y = y ^ (y >> 17);
    y = y ^ (y << 5);
    return y;
  endfunction

  function automatic logic [63:0] rand64();
    logic [31:0] hi;
    rng_state = xorshift32(rng_state);
    hi = rng_state;
    rng_state = xorshift32(rng_state);
    return {hi, rng_state};
  endfunction

  // each row: lane products summed, kept mod 2^16, row r at bits 16r
  function automatic logic [63:0] expected_word(input logic prec, input logic [63:0] act);
    dtpu_pkg::lane_word_u a;
    dtpu_pkg::lane_word_u w;
    logic [63:0]          res;
    longint               acc;
    a = act;
    res = '0;
    for (int r = 0; r < 4; r++) begin
      w = wm_mem[r];
      acc = 0;
      if (prec) begin
        for (int l = 0; l < 4; l++) begin
          acc = acc + longint'($signed(a.h[l])) * longint'($signed(w.h[l]));
        end
      end else begin
        for (int l = 0; l < 8; l++) begin
          acc = acc + longint'($signed(a.b[l])) * longint'($signed(w.b[l]));
        end
      end
      res[16*r +: 16] = acc[15:0];
    end
    return res;
  endfunction

  task automatic flag_error(input string msg);
    $display("** Error at %0t: %s", $time, msg);
    err_cnt++;
  endtask

  task automatic report_timeout(input string what);
    $display("timeout at %0t: %s never happened", $time, what);
    err_cnt++;
  endtask

  task automatic report_test(input string name, input int errs_before);
    test_cnt++;
    if (err_cnt == errs_before) begin
      $display("test %s: ok", name);
    end else begin
      $display("test %s: %0d errors", name, err_cnt - errs_before);
    end
  endtask

  //////////////////////////////
  // models
  //////////////////////////////

  // sample everything mid-cycle, outputs are settled by then
  always @(negedge clk) begin
    if (aresetn === 1'b1) begin
      if (csr_clk !== 1'b0 || wm_clk !== 1'b0) flag_error("memory clock high while clk is low");
      if (csr_we !== 1'b0 || wm_we !== 1'b0 || csr_din !== '0 || wm_din !== '0) begin
        flag_error("memory write port driven");
      end
    end
    csr_pend = csr_ce;
    if (csr_ce) begin
      if (csr_addr > 32'd1) flag_error($sformatf("csr address %0d", csr_addr));
      csr_next = csr_mem[csr_addr[1:0]];
    end
    wm_pend = wm_ce;
    if (wm_ce) begin
      if (wm_addr > 32'd3) flag_error($sformatf("weight address %0d", wm_addr));
      wm_next = wm_mem[wm_addr[1:0]];
    end
    if (outfifo_write) begin
      if (outfifo_full) flag_error("output fifo written while full");
      out_q.push_back(outfifo_din);
      if (pop_cyc_q.size() > 0) begin
        if (lat_check && cyc - pop_cyc_q[0] != 2) begin
          flag_error($sformatf("write %0d cycles after pop", cyc - pop_cyc_q[0]));
        end
        void'(pop_cyc_q.pop_front());
      end
    end
    if (infifo_read) begin
      if (infifo_empty) begin
        flag_error("input fifo popped while empty");
      end else begin
        void'(in_q.pop_front());
        pop_cyc_q.push_back(cyc);
      end
    end
    if (cs_ready) ready_cnt++;
    cyc++;
  end

  always @(posedge clk) begin
    #1;
    if (csr_clk !== 1'b1 || wm_clk !== 1'b1) flag_error("memory clock low while clk is high");
    if (csr_pend) csr_dout = csr_next; // one clock after ce
    if (wm_pend) wm_dout = wm_next;
    pat_state = xorshift32(pat_state);
    outfifo_full = bp_on && pat_state[3];
    infifo_empty = (gap_on && pat_state[7]) || (in_q.size() == 0);
    infifo_dout = (in_q.size() > 0) ? in_q[0] : '0;
  end

  //////////////////////////////
  // one job, start to idle
  //////////////////////////////

  task automatic run_job(input logic prec, input int count, input int n_words,
                         input logic bp, input logic gaps, input int hold);
    logic [63:0] exp_q [$];
    logic [63:0] act;
    int          n;
    @(negedge clk);
    act = rand64();
    csr_mem[0] = {act[7:1], prec}; // only bit 0 counts
    csr_mem[1] = 8'(count);
    for (int r = 0; r < 4; r++) wm_mem[r] = rand64();
    in_q.delete();
    out_q.delete();
    pop_cyc_q.delete();
    for (int i = 0; i < n_words; i++) begin
      act = rand64();
      in_q.push_back(act);
      if (i < count) exp_q.push_back(expected_word(prec, act));
    end
    bp_on = bp;
    gap_on = gaps;
    lat_check = !bp;

    @(posedge clk);
    #1 cs_start = 1'b1;
    n = 0;
    @(negedge clk);
    while (!cs_ready && n < 20) begin
      @(negedge clk);
      n++;
    end
    if (!cs_ready) report_timeout("ready after start");
    if (cs_ready && cs_idle) flag_error("idle high while the job runs");
    @(posedge clk);
    #1 cs_start = 1'b0;

    n = 0;
    while (!cs_done && n < 4000) begin
      @(negedge clk);
      n++;
    end
    if (!cs_done) report_timeout("done");
    for (int i = 0; i < hold; i++) begin
      @(negedge clk);
      if (!cs_done) flag_error("done dropped before continue");
    end
    @(posedge clk);
    #1 cs_continue = 1'b1;
    @(posedge clk);
    #1 cs_continue = 1'b0;
    @(negedge clk);
    if (!cs_idle || cs_done) flag_error("not idle after continue");

    bp_on = 1'b0;
    gap_on = 1'b0;
    if (out_q.size() != exp_q.size()) begin
      flag_error($sformatf("%0d results, expected %0d", out_q.size(), exp_q.size()));
    end
    for (int i = 0; i < exp_q.size() && i < out_q.size(); i++) begin
      if (out_q[i] !== exp_q[i]) begin
        flag_error($sformatf("result %0d is %h, expected %h", i, out_q[i], exp_q[i]));
      end
    end
    if (in_q.size() != n_words - count) begin
      flag_error($sformatf("%0d words left in input fifo", in_q.size()));
    end
  endtask

  //////////////////////////////
  // tests
  //////////////////////////////

  task automatic test_reset_idle();
    int errs0;
    errs0 = err_cnt;
    @(negedge clk);
    if (!cs_idle || cs_ready || cs_done) flag_error("control strobes wrong after reset");
    if (infifo_read || outfifo_write || csr_ce || wm_ce) flag_error("strobe high after reset");
    if (csr_we || wm_we) flag_error("memory write enable high");
    ready_cnt = 0;
    run_job(1'b0, 1, 1, 1'b0, 1'b0, 0);
    if (ready_cnt != 1) flag_error($sformatf("%0d ready pulses", ready_cnt));
    report_test("reset and idle", errs0);
  endtask

  task automatic test_int8();
    int errs0;
    errs0 = err_cnt;
    run_job(1'b0, 6, 6, 1'b0, 1'b0, 0);
    report_test("int8 run", errs0);
  endtask

  task automatic test_int16();
    int errs0;
    errs0 = err_cnt;
    run_job(1'b1, 6, 6, 1'b0, 1'b0, 0);
    report_test("int16 run", errs0);
  endtask

  task automatic test_backpressure();
    int errs0;
    errs0 = err_cnt;
    run_job(1'b0, 12, 12, 1'b1, 1'b0, 0);
    run_job(1'b1, 12, 12, 1'b1, 1'b1, 0); // gaps and full together
    report_test("back-pressure", errs0);
  endtask

  task automatic test_starve_zero();
    int errs0;
    errs0 = err_cnt;
    run_job(1'b0, 8, 8, 1'b0, 1'b1, 0);
    run_job(1'b0, 0, 2, 1'b0, 1'b0, 0); // both words must stay queued
    report_test("starvation and zero count", errs0);
  endtask

  task automatic test_done_continue();
    int errs0;
    errs0 = err_cnt;
    run_job(1'b1, 3, 3, 1'b0, 1'b0, 8);
    run_job(1'b0, 4, 4, 1'b0, 1'b0, 3); // new weights
    report_test("done and continue", errs0);
  endtask

  initial begin
    int n;
    rng_state = 32'd78525;
    pat_state = 32'd78525;
    cs_start = 1'b0;
    cs_continue = 1'b0;
    csr_dout = '0;
    wm_dout = '0;
    infifo_dout = '0;
    infifo_empty = 1'b1;
    outfifo_full = 1'b0;
    csr_pend = 1'b0;
    csr_next = '0;
    wm_pend = 1'b0;
    wm_next = '0;
    bp_on = 1'b0;
    gap_on = 1'b0;
    lat_check = 1'b0;
    cyc = 0;
    ready_cnt = 0;
    err_cnt = 0;
    test_cnt = 0;

    n = 0;
    while (aresetn !== 1'b1 && n < 50) begin
      @(posedge clk);
      n++;
    end
    if (aresetn !== 1'b1) report_timeout("reset release");

    test_reset_idle();
    test_int8();
    test_int16();
    test_backpressure();
    test_starve_zero();
    test_done_continue();

    $display("tests: %0d run, %0d errors", test_cnt, err_cnt);
    if (err_cnt == 0) begin
      $display("ALL CHECKS PASSED");
    end else begin
      $display("CHECKS FAILED");
    end
    $finish;
  end

endmodule

// File: dtpu.f
hw/dtpu_pkg.sv
hw/dtpu_counter.sv
hw/dtpu_control.sv
hw/weight_buffer.sv
hw/mxu.sv
hw/dtpu_core.sv
verif/tb_clock_gen.sv
verif/tb_dtpu.sv

// File: Makefile
SRCS := $(wildcard hw/*.sv verif/*.sv)

run: obj_dir/Vtb_dtpu
	@out="$$(./obj_dir/Vtb_dtpu)"; echo "$$out"; echo "$$out" | grep -q "^ALL CHECKS PASSED$$"

obj_dir/Vtb_dtpu: dtpu.f $(SRCS)
	verilator --binary --timing --assert -Wno-fatal --top-module tb_dtpu -f dtpu.f

clean:
	rm -rf obj_dir

.PHONY: run clean
